// ==== btb_predictor.f ====
+incdir+.
btb_pkg.sv
btb_bank.sv
return_stack.sv
next_pc_ctrl.sv
btb_predictor.sv
tb_btb_predictor.sv

// ==== Makefile ====
# Verilator build and run of the branch predictor testbench
TOP := tb_btb_predictor

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
	  -f btb_predictor.f -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then \
	  echo "run failed, see sim.log"; exit 1; \
	fi
	@grep -q "SIMULATION PASSED" sim.log || (echo "run ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

// ==== btb_ref_model.svh ====
// reference model, included in the testbench module after its signal declarations
// one lookup stage, commit written one edge after capture, ring stack growing down
`ifndef BTB_REF_MODEL_SVH
`define BTB_REF_MODEL_SVH

localparam int IDX_W = $clog2(BTB_DEPTH);
localparam int SP_W  = $clog2(RAS_DEPTH);

logic                 m_vld [NUM_SLOTS][BTB_DEPTH];   // shadow BTB valid
logic [2*PC_W-1:0]    m_ent [NUM_SLOTS][BTB_DEPTH];   // {branch pc, target}
logic                 p_wr  [NUM_SLOTS];              // captured commit, written next edge
logic [2*PC_W-1:0]    p_ent [NUM_SLOTS];
logic [IDX_W-1:0]     p_idx;
logic                 lk_vld;                         // lookup stage
pc_t                  lk_pc;
logic [NUM_SLOTS-1:0] lk_grp;
logic                 lk_hv  [NUM_SLOTS];             // row as read at the sample edge
logic [2*PC_W-1:0]    lk_ent [NUM_SLOTS];
pc_t                  r_stk [RAS_DEPTH];              // shadow return stack
logic [SP_W-1:0]      r_sp;

// one rising edge, inputs as seen at that edge
task automatic model_edge();
  logic [IDX_W-1:0] ri;
  ri = fetch_pc[IDX_LSB +: IDX_W];
  if (rst) begin
    lk_vld = 1'b0;
    r_sp   = '0;
    for (int i = 0; i < RAS_DEPTH; i++)
      r_stk[i] = RST_PC;
    for (int s = 0; s < NUM_SLOTS; s++) begin
      p_wr[s] = 1'b0;
      for (int i = 0; i < BTB_DEPTH; i++)
        m_vld[s][i] = 1'b0;
    end
  end else begin
    lk_vld = en;
    if (en) begin
      lk_pc  = fetch_pc;
      lk_grp = grp_end;
      for (int s = 0; s < NUM_SLOTS; s++) begin
        lk_hv[s]  = m_vld[s][ri];                     // old row, write lands after
        lk_ent[s] = m_ent[s][ri];
      end
    end
    for (int s = 0; s < NUM_SLOTS; s++) begin
      if (p_wr[s]) begin
        m_vld[s][p_idx] = 1'b1;
        m_ent[s][p_idx] = p_ent[s];
      end
      p_wr[s]  = commit_takb[s];                      // not taken never writes
      p_ent[s] = {commit_pc[s], commit_tgt[s]};
    end
    p_idx = commit_pc[0][IDX_LSB +: IDX_W];
    if (do_call) begin
      r_sp        = r_sp - 1'b1;
      r_stk[r_sp] = ret_pc;
    end else if (do_ret) begin
      r_sp = r_sp + 1'b1;
    end
  end
endtask

// expected prediction for the current cycle
function automatic void predict(output pc_t npc, output pc_src_t src,
                                output logic [NUM_SLOTS-1:0] tk);
  logic found;
  npc   = '0;
  src   = SRC_NONE;
  tk    = '0;
  found = 1'b0;
  if (do_ret) begin
    npc = r_stk[r_sp];
    src = SRC_RET;
  end else if (do_bsr) begin
    npc = bsr_tgt;
    src = SRC_BSR;
  end else if (miss) begin
    npc = miss_pc;
    src = SRC_MISS;
  end else if (lk_vld) begin
    for (int s = 0; s < NUM_SLOTS; s++) begin
      if (!found && lk_hv[s] && lk_ent[s][2*PC_W-1:PC_W] == lk_pc + pc_t'(4 * s)) begin
        tk[s] = 1'b1;                                 // lowest slot first
        npc   = lk_ent[s][PC_W-1:0];
        found = 1'b1;
      end
    end
    if (found) begin
      src = SRC_BTB;
    end else begin
      src = SRC_SEQ;
      npc = lk_pc + 32'd16;                           // no group end marked
      for (int s = 0; s < NUM_SLOTS; s++) begin
        if (!found && lk_grp[s]) begin
          npc   = lk_pc + pc_t'(4 * (s + 1));
          found = 1'b1;
        end
      end
    end
  end
endfunction

`endif

// ==== tb_btb_predictor.sv ====
// testbench with a 64-row BTB and 8-entry stack so aliasing and stack wrap show up
// inputs change on the rising edge, predictions are compared at the falling edge

module tb_btb_predictor import btb_pkg::*; ();

  localparam int BTB_DEPTH   = 64;
  localparam int RAS_DEPTH   = 8;
  localparam int RST_CYCLES  = 10;
  localparam int DIR_CYCLES  = 150;   // all directed tests together stay below this
  localparam int RAND_CYCLES = 1500;
  localparam int MAX_CYCLES  = 2 * (RST_CYCLES + DIR_CYCLES + RAND_CYCLES);

  logic clk, rst, en, do_call, do_ret, do_bsr, miss, pred_valid;
  pc_t fetch_pc, ret_pc, bsr_tgt, miss_pc, next_pc;
  pc_t commit_pc [NUM_SLOTS];
  pc_t commit_tgt [NUM_SLOTS];
  logic [NUM_SLOTS-1:0] grp_end, commit_takb, taken;
  pc_src_t pred_src;

  integer seed   = 98392;
  int     errors = 0;
  int     checks = 0;
  int     cycles = 0;

  btb_predictor #(.BTB_DEPTH(BTB_DEPTH), .RAS_DEPTH(RAS_DEPTH)) u_btb_predictor (.*);

  `include "btb_ref_model.svh"

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) model_edge();

  // compare process, outputs are settled mid-cycle
  always @(negedge clk) begin
    if (!rst)
      check_prediction();
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  task automatic report_mismatch(string what, logic [31:0] got, logic [31:0] exp);
    errors++;
    $display("CHECK FAILED @%0t: %s got %h expected %h", $time, what, got, exp);
  endtask

  task automatic check_prediction();
    pc_t                  e_pc;
    pc_src_t              e_src;
    logic [NUM_SLOTS-1:0] e_tk;
    predict(e_pc, e_src, e_tk);
    checks++;
    if (pred_valid !== (e_src != SRC_NONE))
      report_mismatch("pred_valid", pred_valid, e_src != SRC_NONE);
    if (e_src != SRC_NONE) begin                   // next_pc is don't-care when idle
      if (pred_src !== e_src)
        report_mismatch("pred_src", pred_src, e_src);
      if (next_pc !== e_pc)
        report_mismatch("next_pc", next_pc, e_pc);
      if (taken !== e_tk)
        report_mismatch("taken", taken, e_tk);
    end
  endtask

  // ====================
  // stimulus helpers
  // ====================
  task automatic clear_inputs();
    {en, do_call, do_ret, do_bsr, miss} <= '0;
    {fetch_pc, ret_pc, bsr_tgt, miss_pc} <= '0;
    grp_end     <= '0;
    commit_takb <= '0;
    for (int s = 0; s < NUM_SLOTS; s++) begin
      commit_pc[s]  <= '0;
      commit_tgt[s] <= '0;
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    clear_inputs();                                // later drives in the cycle win
  endtask

  task automatic idle(int n);
    repeat (n) next_cycle();
  endtask

  task automatic drive_lookup(pc_t pc, logic [NUM_SLOTS-1:0] grp);
    en       <= 1'b1;
    fetch_pc <= pc;
    grp_end  <= grp;
  endtask

  // whole group commit, slot s branch at base + 4s
  task automatic drive_commit(pc_t base, pc_t tgt, logic [NUM_SLOTS-1:0] takb);
    commit_takb <= takb;
    for (int s = 0; s < NUM_SLOTS; s++) begin
      commit_pc[s]  <= base + pc_t'(4 * s);
      commit_tgt[s] <= tgt + pc_t'(64 * s);
    end
  endtask

  function automatic pc_t pick_group(int r);
    return 32'h8000 + pc_t'((r & 7) << 4) + (((r & 8) != 0) ? pc_t'(32'h400) : pc_t'(0));
  endfunction

  task automatic finish_test(string name, int e0);
    $display("test %-14s done, %0d errors", name, errors - e0);
  endtask

  // ====================
  // tests
  // ====================
  task automatic test_seq();
    int e0;
    e0 = errors;
    for (int g = 0; g < 16; g++) begin             // every grp_end pattern
      next_cycle();
      drive_lookup(32'h1000 + pc_t'(g * 16), 4'(g));
    end
    idle(2);
    finish_test("seq_advance", e0);
  endtask

  task automatic test_hit();
    int e0;
    e0 = errors;
    next_cycle();
    drive_commit(32'h2000, 32'hA000, 4'b0110);
    next_cycle();
    drive_lookup(32'h2000, 4'b0000);               // one edge too early
    next_cycle();
    drive_lookup(32'h2000, 4'b0000);               // slot 1 wins over slot 2
    next_cycle();
    drive_commit(32'h2100, 32'hB000, 4'b0000);     // not taken
    idle(2);
    drive_lookup(32'h2100, 4'b1000);
    next_cycle();
    drive_commit(32'h2200, 32'hC000, 4'b1000);
    idle(2);
    drive_lookup(32'h2200, 4'b0000);
    idle(2);
    finish_test("train_hit", e0);
  endtask

  task automatic test_alias();
    int e0;
    e0 = errors;
    next_cycle();
    drive_commit(32'h3000, 32'hD000, 4'b0001);
    idle(2);
    drive_lookup(32'h3400, 4'b0000);               // same row, other tag
    next_cycle();
    drive_lookup(32'h3000, 4'b0000);
    idle(2);
    finish_test("alias_miss", e0);
  endtask

  task automatic test_ras();
    int e0;
    e0 = errors;
    for (int i = 0; i < 5; i++) begin
      next_cycle();
      do_call <= 1'b1;
      ret_pc  <= 32'h5000 + pc_t'(i * 16);
    end
    for (int i = 0; i < 5; i++) begin
      next_cycle();
      drive_lookup(32'h3000, 4'b0000);             // keeps a BTB hit pending
      do_ret <= 1'b1;
    end
    idle(2);
    finish_test("return_stack", e0);
  endtask

  task automatic test_prio();
    int e0;
    e0 = errors;
    for (int c = 0; c < 16; c++) begin
      next_cycle();
      if (c[3])
        drive_lookup(32'h3000, 4'b0000);
      do_ret  <= c[0];
      do_bsr  <= c[1];
      miss    <= c[2];
      bsr_tgt <= 32'hE000 + pc_t'(c);
      miss_pc <= 32'hF000 + pc_t'(c);
    end
    idle(2);
    finish_test("redirect_prio", e0);
  endtask

  task automatic test_random();
    int e0;
    int r;
    e0 = errors;
    for (int n = 0; n < RAND_CYCLES; n++) begin
      next_cycle();
      r = $random(seed);
      if (r[0])
        drive_lookup(pick_group($random(seed)), 4'($random(seed)));
      if (r[3:1] == 3'd0)
        drive_commit(pick_group($random(seed)), $random(seed), 4'($random(seed)));
      if (r[6:4] == 3'd0) begin                    // call and return never together
        do_call <= 1'b1;
        ret_pc  <= $random(seed);
      end else if (r[6:4] == 3'd1) begin
        do_ret <= 1'b1;
      end
      if (r[9:7] == 3'd0) begin
        do_bsr  <= 1'b1;
        bsr_tgt <= $random(seed);
      end
      if (r[12:10] == 3'd0) begin
        miss    <= 1'b1;
        miss_pc <= $random(seed);
      end
    end
    idle(2);
    finish_test("random_mix", e0);
  endtask

  initial begin
    rst <= 1'b1;
    clear_inputs();
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    test_seq();
    test_hit();
    test_alias();
    test_ras();
    test_prio();
    test_random();
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== btb_predictor.sv ====
// fetch-side branch predictor top, one BTB bank per slot plus return stack
// single fetch stream, plain strobes and levels with no handshake or back-pressure
// commit_* are sampled every edge, all four slots share the row of commit_pc[0]

module btb_predictor import btb_pkg::*; #(
  parameter int BTB_DEPTH = 1024,   // rows per slot bank
  parameter int RAS_DEPTH = 32      // return stack entries
) (
  input  logic                 clk,
  input  logic                 rst,
  // fetch
  input  logic                 en,
  input  pc_t                  fetch_pc,
  input  logic [NUM_SLOTS-1:0] grp_end,
  // commit training
  input  pc_t                  commit_pc  [NUM_SLOTS],
  input  pc_t                  commit_tgt [NUM_SLOTS],
  input  logic [NUM_SLOTS-1:0] commit_takb,
  // call and return
  input  logic                 do_call,
  input  logic                 do_ret,
  input  pc_t                  ret_pc,
  // redirects
  input  logic                 do_bsr,
  input  pc_t                  bsr_tgt,
  input  logic                 miss,
  input  pc_t                  miss_pc,
  // prediction
  output pc_t                  next_pc,
  output pc_src_t              pred_src,
  output logic                 pred_valid,
  output logic [NUM_SLOTS-1:0] taken
);

  pc_t                  look_pc;        // lookup stage address, back to the banks
  logic [NUM_SLOTS-1:0] bank_hit;
  pc_t                  bank_tgt [NUM_SLOTS];
  pc_t                  ras_top;

  // ====================
  // slot banks
  // ====================
  for (genvar g = 0; g < NUM_SLOTS; g++) begin : g_bank
    btb_bank #(
      .BTB_DEPTH (BTB_DEPTH),
      .SLOT      (g)
    ) u_btb_bank (
      .clk       (clk),
      .rst       (rst),
      .rd_en     (en),
      .rd_pc     (fetch_pc),          // every bank indexed by the slot-0 address
      .look_pc   (look_pc),
      .wr_pc     (commit_pc[g]),
      .wr_idx_pc (commit_pc[0]),
      .wr_tgt    (commit_tgt[g]),
      .wr_takb   (commit_takb[g]),
      .hit       (bank_hit[g]),
      .tgt       (bank_tgt[g])
    );
  end

  return_stack #(
    .RAS_DEPTH (RAS_DEPTH)
  ) u_return_stack (
    .clk     (clk),
    .rst     (rst),
    .push    (do_call),
    .pop     (do_ret),
    .push_pc (ret_pc),
    .top     (ras_top)
  );

  next_pc_ctrl u_next_pc_ctrl (
    .clk        (clk),
    .rst        (rst),
    .en         (en),
    .fetch_pc   (fetch_pc),
    .grp_end    (grp_end),
    .bank_hit   (bank_hit),
    .bank_tgt   (bank_tgt),
    .ras_top    (ras_top),
    .do_ret     (do_ret),
    .do_bsr     (do_bsr),
    .miss       (miss),
    .bsr_tgt    (bsr_tgt),
    .miss_pc    (miss_pc),
    .look_pc    (look_pc),
    .next_pc    (next_pc),
    .pred_src   (pred_src),
    .pred_valid (pred_valid),
    .taken      (taken)
  );

endmodule

// ==== next_pc_ctrl.sv ====
// lookup stage and next-PC priority select
// redirect strobes act in the same cycle, BTB and sequential results one cycle
// after the fetch address was sampled, next_pc is don't-care while pred_valid is low

module next_pc_ctrl import btb_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 en,                    // sample fetch_pc this edge
  input  pc_t                  fetch_pc,
  input  logic [NUM_SLOTS-1:0] grp_end,               // slot that closes the group
  input  logic [NUM_SLOTS-1:0] bank_hit,
  input  pc_t                  bank_tgt [NUM_SLOTS],
  input  pc_t                  ras_top,
  input  logic                 do_ret,
  input  logic                 do_bsr,
  input  logic                 miss,
  input  pc_t                  bsr_tgt,
  input  pc_t                  miss_pc,
  output pc_t                  look_pc,               // to the banks for tag compare
  output pc_t                  next_pc,
  output pc_src_t              pred_src,
  output logic                 pred_valid,
  output logic [NUM_SLOTS-1:0] taken
);

  logic [NUM_SLOTS-1:0] look_grp;       // grp_end held with look_pc
  logic                 look_vld;       // lookup result due this cycle

  pc_t                  seq_step;
  logic [NUM_SLOTS-1:0] hit_oh;         // lowest hitting slot
  pc_t                  hit_tgt;

  // ====================
  // lookup stage
  // ====================
  always_ff @(posedge clk) begin
    if (rst) begin
      look_vld <= 1'b0;
    end else begin
      look_vld <= en;                   // one lookup per cycle, no stall
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      look_pc  <= fetch_pc;
      look_grp <= grp_end;
    end
  end

  // step to the slot after the first group end, whole group when none is marked
  always_comb begin
    seq_step = pc_t'(GROUP_BYTES);
    for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
      if (look_grp[i]) begin
        seq_step = pc_t'((i + 1) * INSN_BYTES);   // lower slots overwrite higher
      end
    end
  end

  // lowest slot wins among taken hits
  always_comb begin
    hit_oh  = '0;
    hit_tgt = '0;
    for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
      if (bank_hit[i]) begin
        hit_oh    = '0;
        hit_oh[i] = 1'b1;
        hit_tgt   = bank_tgt[i];
      end
    end
  end

  // ====================
  // priority select
  // ====================
  // ret > bsr > miss > btb hit > sequential
  always_comb begin
    next_pc  = look_pc + seq_step;      // also the value shown when idle
    pred_src = SRC_NONE;
    taken    = '0;
    if (do_ret) begin
      next_pc  = ras_top;
      pred_src = SRC_RET;
    end else if (do_bsr) begin
      next_pc  = bsr_tgt;
      pred_src = SRC_BSR;
    end else if (miss) begin
      next_pc  = miss_pc;
      pred_src = SRC_MISS;
    end else if (look_vld && |bank_hit) begin
      next_pc  = hit_tgt;
      pred_src = SRC_BTB;
      taken    = hit_oh;                // only a BTB hit raises taken
    end else if (look_vld) begin
      pred_src = SRC_SEQ;
    end
  end

  // any strobe or a lookup in flight gives a prediction
  assign pred_valid = do_ret | do_bsr | miss | look_vld;

  // taken is one-hot at most and only ever comes with a BTB prediction
  a_taken_oh: assert property (@(posedge clk) disable iff (rst)
    $onehot0(taken) && ((|taken) == (pred_src == SRC_BTB)))
    else $error("next_pc_ctrl taken %b with source %s", taken, pred_src.name());

  // valid term and priority chain must agree
  a_valid_src: assert property (@(posedge clk) disable iff (rst)
    pred_valid != (pred_src == SRC_NONE))
    else $error("next_pc_ctrl pred_valid disagrees with source");

endmodule

// ==== return_stack.sv ====
// circular return-address stack, overflow silently drops the oldest return
// push and pop in the same cycle is not supported

module return_stack import btb_pkg::*; #(
  parameter int RAS_DEPTH = 32          // entries, power of two
) (
  input  logic clk,
  input  logic rst,
  input  logic push,                    // call, store push_pc
  input  logic pop,                     // return, drop the top
  input  pc_t  push_pc,                 // return address of the call
  output pc_t  top
);

  localparam int SP_W = $clog2(RAS_DEPTH);

  pc_t            stk [RAS_DEPTH];
  logic [SP_W-1:0] sp;                  // points at the current top
  logic [SP_W-1:0] sp_dn;

  assign sp_dn = sp - 1'b1;             // wraps, so the ring just rolls over

  // ====================
  // pointer
  // ====================
  always_ff @(posedge clk) begin
    if (rst) begin
      sp <= '0;
    end else if (push) begin
      sp <= sp_dn;                      // grows downward
    end else if (pop) begin
      sp <= sp + 1'b1;
    end
  end

  // entries come up holding the reset vector
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < RAS_DEPTH; i++) begin
        stk[i] <= RST_PC;
      end
    end else if (push) begin
      stk[sp_dn] <= push_pc;
    end
  end

  assign top = stk[sp];                 // valid before the pop edge

  // call and return are exclusive at the fetch unit
  a_no_push_pop: assert property (@(posedge clk) disable iff (rst)
    !(push && pop))
    else $error("return_stack push and pop together");

endmodule

// ==== btb_bank.sv ====
// one slot bank of the BTB, a single write port fed from commit and one read port
// commit writes land one edge after capture, so a lookup sees them two edges later
// BTB_DEPTH must be a power of two, entries carry the full branch PC as tag

module btb_bank import btb_pkg::*; #(
  parameter int BTB_DEPTH = 1024,   // rows in this bank
  parameter int SLOT      = 0       // instruction slot served, 0 .. NUM_SLOTS-1
) (
  input  logic clk,
  input  logic rst,
  input  logic rd_en,       // lookup strobe, samples rd_pc
  input  pc_t  rd_pc,       // slot-0 fetch address
  input  pc_t  look_pc,     // fetch address held in the lookup stage
  input  pc_t  wr_pc,       // committed branch address for this slot
  input  pc_t  wr_idx_pc,   // slot-0 commit address, picks the row
  input  pc_t  wr_tgt,      // committed branch target
  input  logic wr_takb,     // branch was taken, entry gets written
  output logic hit,
  output pc_t  tgt
);

  localparam int  IDX_W    = $clog2(BTB_DEPTH);
  localparam pc_t SLOT_OFS = pc_t'(SLOT * INSN_BYTES);   // byte offset of this slot

  typedef struct packed {
    pc_t  pc;
    pc_t  tgt;
  } btb_entry_t;

  btb_entry_t           mem [BTB_DEPTH];   // inferred simple dual-port array
  logic [BTB_DEPTH-1:0] vld;               // taken flag per row, set by a taken commit

  // commit side
  btb_entry_t       wr_ent;
  logic [IDX_W-1:0] wr_idx;
  logic             wr_q;                  // write pending at next edge

  // lookup side
  logic [IDX_W-1:0] rd_idx;
  btb_entry_t       rd_ent;
  logic             rd_vld;

  assign rd_idx = rd_pc[IDX_LSB +: IDX_W];

  // ====================
  // training path
  // ====================
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_q <= 1'b0;
    end else begin
      wr_q <= wr_takb;                     // not-taken commits never write
    end
  end

  always_ff @(posedge clk) begin
    wr_ent.pc   <= wr_pc;
    wr_ent.tgt  <= wr_tgt;
    wr_idx      <= wr_idx_pc[IDX_LSB +: IDX_W];   // all slots share the group row
  end

  always_ff @(posedge clk) begin
    if (wr_q) begin
      mem[wr_idx] <= wr_ent;
    end
  end

  // valid bits stand in for clearing the whole array
  always_ff @(posedge clk) begin
    if (rst) begin
      vld <= '0;
    end else if (wr_q) begin
      vld[wr_idx] <= 1'b1;
    end
  end

  // ====================
  // lookup path
  // ====================
  // read before write on a same-row collision
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_ent <= mem[rd_idx];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_vld <= 1'b0;
    end else if (rd_en) begin
      rd_vld <= vld[rd_idx];
    end
  end

  // tag is the full branch address of this slot within the looked-up group
  assign hit = rd_vld & (rd_ent.pc == look_pc + SLOT_OFS);
  assign tgt = rd_ent.tgt;

  // a commit captured just before reset must not land in the reset cycle
  a_no_wr_in_rst: assert property (@(posedge clk)
    rst |-> (wr_q !== 1'b1))
    else $error("btb_bank slot %0d wrote during reset", SLOT);

endmodule

// ==== btb_pkg.sv ====
// shared widths, PC type and next-PC source encoding for the branch predictor
// a fetch group is 16 bytes holding 4 fixed 4-byte slots, addresses byte based
// the BTB index starts at bit 4 so every slot of one group lands on the same row

package btb_pkg;

  // ====================
  // address widths
  // ====================
  localparam int PC_W = 32;                  // fetch and commit address width

  typedef logic [PC_W-1:0] pc_t;             // byte address of an instruction

  // ====================
  // fetch group geometry
  // ====================
  localparam int NUM_SLOTS   = 4;            // instruction slots per group
  localparam int INSN_BYTES  = 4;            // fixed instruction size
  localparam int GROUP_BYTES = NUM_SLOTS * INSN_BYTES;  // default sequential step
  localparam int IDX_LSB     = 4;            // lowest BTB index bit, group aligned

  // power-on value of every return-stack entry
  localparam pc_t RST_PC = 32'hFFFC0000;

  // ====================
  // next-PC source
  // ====================
  // listed in no particular order, priority lives in next_pc_ctrl
  typedef enum logic [2:0] {
    SRC_NONE = 3'd0,   // nothing to predict this cycle
    SRC_RET  = 3'd1,   // return, top of stack
    SRC_BSR  = 3'd2,   // subroutine jump target
    SRC_MISS = 3'd3,   // branch-miss redirect
    SRC_BTB  = 3'd4,   // taken hit in one of the slot banks
    SRC_SEQ  = 3'd5    // fall through to the next group
  } pc_src_t;

endpackage
